// File: design/snd_pkg.sv
/*
 * QSound sound board shared definitions
 * Z80 memory map, DSP register page, interrupt timer period and the
 * main-CPU address windows that reach the shared RAM (CPS1 layout)
 */
package snd_pkg;

    // Z80 address regions
    typedef enum logic [2:0] {
        REGION_ROM_LO,   // 0000-7FFF
        REGION_ROM_BANK, // 8000-BFFF
        REGION_RAM,      // C000-CFFF and F000-FFFF
        REGION_DSP,      // D000-DFFF
        REGION_NONE
    } snd_region_e;

    localparam int ROM_AW = 19;  // 512 kB program ROM
    localparam int RAM_AW = 13;  // 8 kB shared RAM

    // banked window starts right after the linear 32 kB
    localparam logic [ROM_AW-1:0] BANK_BASE = 19'h0_8000;

    // low address bits inside the DSP page
    localparam logic [2:0] DSP_CMD_LO  = 3'd0;
    localparam logic [2:0] DSP_CMD_MID = 3'd1;
    localparam logic [2:0] DSP_CMD_HI  = 3'd2;  // also raises the DSP irq
    localparam logic [2:0] DSP_BANK    = 3'd3;
    localparam logic [2:0] DSP_STATUS  = 3'd7;

    // Z80 interrupt every 32000 ticks of the 8 MHz enable, i.e. 250 Hz
    localparam int INT_PERIOD = 32000;
    localparam int INT_CNT_W  = $clog2(INT_PERIOD);
    localparam logic [INT_CNT_W-1:0] INT_LAST = INT_CNT_W'(INT_PERIOD - 1);

    // main address bits 23:12, half-open windows [lo, hi)
    localparam logic [11:0] LOCK_WIN_A_LO = 12'hf18;
    localparam logic [11:0] LOCK_WIN_A_HI = 12'hf1a;
    localparam logic [11:0] LOCK_WIN_B_LO = 12'hf1e;
    localparam logic [11:0] LOCK_WIN_B_HI = 12'hf20;

endpackage

// File: design/sound_bus_ctrl.sv
/*
 * Z80 bus controller for the sound board
 * Decodes the Z80 memory map into registered chip selects, forms the
 * linear or banked ROM address, holds the bank and DSP reset register,
 * inserts one wait tick on opcode fetches above 0x4000 and muxes the
 * CPU read data
 */
`timescale 1ns/1ps

module sound_bus_ctrl (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen8,
    input  logic [15:0] z80_addr,
    input  logic [7:0]  z80_dout,
    input  logic        mreq_n,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic        m1_n,
    input  logic [7:0]  rom_data,
    input  logic [7:0]  ram_dout,
    input  logic        dsp_irq,
    input  logic        dsp_iack,
    output logic [18:0] rom_addr,
    output logic        rom_cs,
    output logic        ram_cs,
    output logic        cmd_wr,
    output logic [1:0]  cmd_sel,
    output logic        dsp_rst,
    output logic        cpu_cen,
    output logic [7:0]  z80_din
);

    snd_pkg::snd_region_e region;
    logic       bank_cs;
    logic       stat_rd;
    logic [3:0] bank;
    logic       wait_done;  // wait tick already spent in this fetch
    logic       fetch_hi;
    logic       dsp_rdy_n;
    logic       dsp_page;

    always_comb begin
        if (!z80_addr[15]) begin
            region = snd_pkg::REGION_ROM_LO;
        end else if (!z80_addr[14]) begin
            region = snd_pkg::REGION_ROM_BANK;
        end else begin
            case (z80_addr[13:12])
                2'b00:   region = snd_pkg::REGION_RAM;   // C000
                2'b01:   region = snd_pkg::REGION_DSP;   // D000
                2'b11:   region = snd_pkg::REGION_RAM;   // F000 mirror
                default: region = snd_pkg::REGION_NONE;
            endcase
        end
    end

    assign dsp_page = !mreq_n && (region == snd_pkg::REGION_DSP);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs   <= 1'b0;
            ram_cs   <= 1'b0;
            cmd_wr   <= 1'b0;
            cmd_sel  <= 2'd0;
            bank_cs  <= 1'b0;
            stat_rd  <= 1'b0;
            rom_addr <= '0;
        end else begin
            rom_cs  <= !mreq_n && !rd_n && (region == snd_pkg::REGION_ROM_LO ||
                                            region == snd_pkg::REGION_ROM_BANK);
            ram_cs  <= !mreq_n && (!rd_n || !wr_n) && (region == snd_pkg::REGION_RAM);
            cmd_wr  <= dsp_page && !wr_n && (z80_addr[2:0] <= snd_pkg::DSP_CMD_HI);
            cmd_sel <= z80_addr[1:0];
            bank_cs <= dsp_page && !wr_n && (z80_addr[2:0] == snd_pkg::DSP_BANK);
            stat_rd <= dsp_page && !rd_n && (z80_addr[2:0] == snd_pkg::DSP_STATUS);
            if (!mreq_n) begin
                if (region == snd_pkg::REGION_ROM_BANK)
                    rom_addr <= {1'b0, bank, z80_addr[13:0]} + snd_pkg::BANK_BASE;
                else
                    rom_addr <= {4'b0, z80_addr[14:0]};
            end
        end
    end

    // bank select and DSP reset, bit 7 releases the DSP
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank    <= 4'd0;
            dsp_rst <= 1'b1;
        end else if (bank_cs) begin
            bank    <= z80_dout[3:0];
            dsp_rst <= ~z80_dout[7];
        end
    end

    // one lost cen8 tick per opcode fetch at 4000 and up
    assign fetch_hi = !m1_n && (z80_addr[15:14] != 2'b00);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_done <= 1'b0;
        end else if (cen8) begin
            if (m1_n)
                wait_done <= 1'b0;  // re-arm for next fetch
            else if (fetch_hi)
                wait_done <= 1'b1;
        end
    end

    assign cpu_cen = cen8 & ~(fetch_hi & ~wait_done);

    assign dsp_rdy_n = ~(dsp_irq | dsp_iack);

    always_comb begin
        if (rom_cs)
            z80_din = rom_data;  // opcodes pass undecoded
        else if (ram_cs)
            z80_din = ram_dout;
        else if (stat_rd)
            z80_din = {dsp_rdy_n, 3'b111, bank};
        else
            z80_din = 8'hff;
    end

endmodule

// File: design/int_timer.sv
/*
 * Z80 periodic interrupt
 * Counts cen8 ticks and pulls int_n low every INT_PERIOD ticks,
 * released by the interrupt acknowledge cycle
 */
`timescale 1ns/1ps

module int_timer (
    input  logic clk,
    input  logic rst,
    input  logic cen8,
    input  logic m1_n,
    input  logic iorq_n,
    output logic int_n
);

    logic [snd_pkg::INT_CNT_W-1:0] cnt;
    logic                          wrap;

    assign wrap = (cnt == snd_pkg::INT_LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            int_n <= 1'b1;
        end else if (cen8) begin
            cnt <= wrap ? '0 : cnt + 1'b1;
            if (!m1_n && !iorq_n)
                int_n <= 1'b1;  // ack cycle
            else if (wrap)
                int_n <= 1'b0;
        end
    end

endmodule

// File: design/bus_lock.sv
/*
 * Main CPU access to the Z80 bus
 * A main CPU cycle inside the shared windows requests the Z80 bus, the
 * grant is passed through two cen8 stages before the main CPU sees it.
 * Main writes reach the shared RAM only while granted
 */
`timescale 1ns/1ps

module bus_lock (
    input  logic         clk,
    input  logic         rst,
    input  logic         cen8,
    input  logic [23:12] main_addr,
    input  logic         main_buse_n,
    input  logic         main_ldswn,
    input  logic         z80_busak_n,
    input  logic [3:0]   main_ram_sel,
    output logic         z80_busrq_n,
    output logic         main_busakn,
    output logic         main_we
);

    logic       in_win_a;
    logic       in_win_b;
    logic [1:0] grant;  // active low stages

    assign in_win_a = (main_addr >= snd_pkg::LOCK_WIN_A_LO) &&
                      (main_addr <  snd_pkg::LOCK_WIN_A_HI);
    assign in_win_b = (main_addr >= snd_pkg::LOCK_WIN_B_LO) &&
                      (main_addr <  snd_pkg::LOCK_WIN_B_HI);

    assign z80_busrq_n = main_buse_n | ~(in_win_a | in_win_b);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant <= 2'b11;
        end else if (main_buse_n) begin
            grant <= 2'b11;  // drop at once when main lets go
        end else if (cen8) begin
            grant <= {grant[0], z80_busrq_n | z80_busak_n};
        end
    end

    assign main_busakn = grant[1];

    // only the C000 and F000 RAM pages are writable from the main side
    assign main_we = !main_busakn && !main_ldswn &&
                     (main_ram_sel == 4'hc || main_ram_sel == 4'hf);

endmodule

// File: design/shared_ram.sv
/*
 * 8 kB dual-port RAM shared by the Z80 and the main CPU
 * Both ports read and write synchronously, reads have one cycle latency
 */
`timescale 1ns/1ps

module shared_ram (
    input  logic        clk,
    input  logic [12:0] addr0,
    input  logic [7:0]  data0,
    input  logic        we0,
    input  logic [12:0] addr1,
    input  logic [7:0]  data1,
    input  logic        we1,
    output logic [7:0]  q0,
    output logic [7:0]  q1
);

    logic [7:0] mem [0:(1 << snd_pkg::RAM_AW)-1];

    always_ff @(posedge clk) begin
        if (we0)
            mem[addr0] <= data0;  // Z80 side
        if (we1)
            mem[addr1] <= data1;  // main side, wins on a collision
        q0 <= mem[addr0];
        q1 <= mem[addr1];
    end

endmodule

// File: design/dsp_port.sv
/*
 * Z80 to DSP16 parallel port
 * Builds the 24-bit command from three byte writes, raises the DSP
 * interrupt on the high byte and drops it after the DSP input read.
 * Also latches the sample ROM address put out by the DSP
 */
`timescale 1ns/1ps

module dsp_port (
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_wr,
    input  logic [1:0]  cmd_sel,
    input  logic [7:0]  cmd_data,
    input  logic        dsp_pods_n,
    input  logic        dsp_pids_n,
    input  logic [15:0] dsp_pbus_out,
    input  logic [6:0]  dsp_ab,
    output logic        dsp_irq,
    output logic [15:0] dsp_pbus_in,
    output logic [22:0] qsnd_addr
);

    logic [23:0] cmd;
    logic        last_pods_n;
    logic        last_pids_n;
    logic        pods_rise;
    logic        pids_rise;
    logic        hi_wr;

    assign pods_rise = dsp_pods_n && !last_pods_n;
    assign pids_rise = dsp_pids_n && !last_pids_n;
    assign hi_wr     = cmd_wr && ({1'b0, cmd_sel} == snd_pkg::DSP_CMD_HI);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_pods_n <= 1'b1;
            last_pids_n <= 1'b1;
            dsp_irq     <= 1'b0;
        end else begin
            last_pods_n <= dsp_pods_n;
            last_pids_n <= dsp_pids_n;
            if (hi_wr)
                dsp_irq <= 1'b1;
            else if (pids_rise)
                dsp_irq <= 1'b0;  // DSP has read the high byte
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_wr) begin
            case ({1'b0, cmd_sel})
                snd_pkg::DSP_CMD_LO:  cmd[7:0]   <= cmd_data;
                snd_pkg::DSP_CMD_MID: cmd[15:8]  <= cmd_data;
                snd_pkg::DSP_CMD_HI:  cmd[23:16] <= cmd_data;
                default: ;
            endcase
        end
        if (pods_rise)
            qsnd_addr[15:0] <= dsp_pbus_out;
        qsnd_addr[22:16] <= dsp_ab;  // upper bits straight from the address bus
    end

    // high byte goes first while irq is pending, then the low word
    always_comb begin
        if (!dsp_pods_n)
            dsp_pbus_in = dsp_irq ? {8'd0, cmd[23:16]} : cmd[15:0];
        else
            dsp_pbus_in = 16'hffff;
    end

endmodule

// File: design/serial_audio_rx.sv
/*
 * DSP16 serial audio receiver
 * Shifts the serial output in MSB first on falling ock, steering the
 * bits by psel, and presents a stereo pair with a sample pulse on each
 * rising psel
 */
`timescale 1ns/1ps

module serial_audio_rx (
    input  logic               clk,
    input  logic               rst,
    input  logic               sdo,
    input  logic               ock,
    input  logic               psel,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample
);

    logic [15:0] shift_l;
    logic [15:0] shift_r;
    logic        last_ock;
    logic        last_psel;
    logic        ock_fall;
    logic        psel_rise;

    assign ock_fall  = !ock && last_ock;
    assign psel_rise = psel && !last_psel;

    always_ff @(posedge clk) begin
        if (ock_fall) begin
            if (!psel)
                shift_l <= {shift_l[14:0], sdo};
            else
                shift_r <= {shift_r[14:0], sdo};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_ock  <= 1'b0;
            last_psel <= 1'b1;  // no false edge at reset release
            left      <= '0;
            right     <= '0;
            sample    <= 1'b0;
        end else begin
            last_ock  <= ock;
            last_psel <= psel;
            sample    <= psel_rise;
            if (psel_rise) begin
                left  <= shift_l;
                right <= shift_r;
            end
        end
    end

endmodule

// File: design/qsound_glue.sv
/*
 * QSound sound board glue logic, top level
 * Connects the Z80 bus controller, interrupt timer, main CPU bus lock,
 * shared RAM, DSP parallel port and serial audio receiver to the pins
 * of the Z80, the DSP16 and the main CPU
 */
`timescale 1ns/1ps

module qsound_glue (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen8,
    // Z80
    input  logic [15:0]        z80_addr,
    input  logic [7:0]         z80_dout,
    input  logic               mreq_n,
    input  logic               rd_n,
    input  logic               wr_n,
    input  logic               m1_n,
    input  logic               iorq_n,
    input  logic               z80_busak_n,
    output logic [7:0]         z80_din,
    output logic               cpu_cen,
    output logic               int_n,
    output logic               z80_busrq_n,
    // DSP16
    input  logic [15:0]        dsp_ab,
    input  logic [15:0]        dsp_pbus_out,
    input  logic               dsp_pods_n,
    input  logic               dsp_pids_n,
    input  logic               dsp_iack,
    input  logic               dsp_sdo,
    input  logic               dsp_ock,
    input  logic               dsp_psel,
    output logic [15:0]        dsp_pbus_in,
    output logic               dsp_irq,
    output logic               dsp_rst,
    // main CPU
    input  logic [23:1]        main_addr,
    input  logic [7:0]         main_dout,
    input  logic               main_ldswn,
    input  logic               main_buse_n,
    output logic [7:0]         main_din,
    output logic               main_busakn,
    // program ROM
    output logic [18:0]        rom_addr,
    output logic               rom_cs,
    input  logic [7:0]         rom_data,
    // sample ROM and audio
    output logic [22:0]        qsnd_addr,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample
);

    logic       ram_cs;
    logic       cmd_wr;
    logic [1:0] cmd_sel;
    logic       main_we;
    logic [7:0] ram_dout;

    sound_bus_ctrl bus_ctrl_i (
        .clk      (clk),
        .rst      (rst),
        .cen8     (cen8),
        .z80_addr (z80_addr),
        .z80_dout (z80_dout),
        .mreq_n   (mreq_n),
        .rd_n     (rd_n),
        .wr_n     (wr_n),
        .m1_n     (m1_n),
        .rom_data (rom_data),
        .ram_dout (ram_dout),
        .dsp_irq  (dsp_irq),
        .dsp_iack (dsp_iack),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .ram_cs   (ram_cs),
        .cmd_wr   (cmd_wr),
        .cmd_sel  (cmd_sel),
        .dsp_rst  (dsp_rst),
        .cpu_cen  (cpu_cen),
        .z80_din  (z80_din)
    );

    int_timer int_timer_i (
        .clk    (clk),
        .rst    (rst),
        .cen8   (cen8),
        .m1_n   (m1_n),
        .iorq_n (iorq_n),
        .int_n  (int_n)
    );

    bus_lock bus_lock_i (
        .clk          (clk),
        .rst          (rst),
        .cen8         (cen8),
        .main_addr    (main_addr[23:12]),
        .main_buse_n  (main_buse_n),
        .main_ldswn   (main_ldswn),
        .z80_busak_n  (z80_busak_n),
        .main_ram_sel (main_addr[16:13]),
        .z80_busrq_n  (z80_busrq_n),
        .main_busakn  (main_busakn),
        .main_we      (main_we)
    );

    // main CPU sees the RAM on its low byte lane, word addressed
    shared_ram shared_ram_i (
        .clk   (clk),
        .addr0 (z80_addr[12:0]),
        .data0 (z80_dout),
        .we0   (ram_cs & ~wr_n),
        .addr1 (main_addr[13:1]),
        .data1 (main_dout),
        .we1   (main_we),
        .q0    (ram_dout),
        .q1    (main_din)
    );

    dsp_port dsp_port_i (
        .clk          (clk),
        .rst          (rst),
        .cmd_wr       (cmd_wr),
        .cmd_sel      (cmd_sel),
        .cmd_data     (z80_dout),
        .dsp_pods_n   (dsp_pods_n),
        .dsp_pids_n   (dsp_pids_n),
        .dsp_pbus_out (dsp_pbus_out),
        .dsp_ab       (dsp_ab[6:0]),
        .dsp_irq      (dsp_irq),
        .dsp_pbus_in  (dsp_pbus_in),
        .qsnd_addr    (qsnd_addr)
    );

    serial_audio_rx audio_rx_i (
        .clk    (clk),
        .rst    (rst),
        .sdo    (dsp_sdo),
        .ock    (dsp_ock),
        .psel   (dsp_psel),
        .left   (left),
        .right  (right),
        .sample (sample)
    );

endmodule

// File: verification/tb_qsound_glue.sv
/*
 * Testbench for the QSound glue logic
 * Plays Z80, DSP16 and main CPU with seeded random stimulus and checks
 * the DUT against a behavioural model of the bank, command latch, irq
 * flag, shared RAM, audio shifters and interrupt timer
 */
`timescale 1ns/1ps

module tb_qsound_glue;

    localparam int ROM_ITERS    = 8;
    localparam int CMD_ITERS    = 4;
    localparam int AUDIO_FRAMES = 6;
    localparam int QADDR_ITERS  = 8;
    localparam int RAM_ITERS    = 8;
    localparam int RUN_CYCLES   = 10 + ROM_ITERS * 32 + CMD_ITERS * 32 + AUDIO_FRAMES * 72 +
                                  QADDR_ITERS * 8 + RAM_ITERS * 24 +
                                  2 * snd_pkg::INT_PERIOD + 64;

    logic clk, rst, cen8;
    logic [15:0] z80_addr;
    logic [7:0] z80_dout, z80_din, rom_data, main_dout, main_din;
    logic mreq_n, rd_n, wr_n, m1_n, iorq_n, z80_busak_n;
    logic cpu_cen, int_n, z80_busrq_n;
    logic [15:0] dsp_ab, dsp_pbus_out, dsp_pbus_in;
    logic dsp_pods_n, dsp_pids_n, dsp_iack, dsp_sdo, dsp_ock, dsp_psel;
    logic dsp_irq, dsp_rst;
    logic [23:1] main_addr;
    logic main_ldswn, main_buse_n, main_busakn;
    logic [18:0] rom_addr;
    logic rom_cs, sample;
    logic [22:0] qsnd_addr;
    logic signed [15:0] left, right;

    // model state
    logic [31:0] seed;
    logic [3:0]  m_bank;
    logic        m_dsp_rst;
    logic [23:0] m_cmd;
    logic        m_irq;
    logic [7:0]  m_ram [0:8191];
    logic [15:0] m_shift_l, m_shift_r;
    int          edges;   // clock edges since reset release
    int          pulses;  // sample pulses seen

    qsound_glue dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst)
            edges <= 0;
        else
            edges <= edges + 1;
    end

    always @(negedge clk) begin
        if (rst)
            pulses <= 0;
        else if (sample)
            pulses <= pulses + 1;  // mid-cycle, outputs settled
    end

    initial begin
        #(RUN_CYCLES * 20);
        abort_run("watchdog expired before the tests finished");
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic snd_pkg::snd_region_e region_of(input logic [15:0] a);
        if (a < 16'h8000) return snd_pkg::REGION_ROM_LO;
        if (a < 16'hc000) return snd_pkg::REGION_ROM_BANK;
        if (a < 16'hd000 || a >= 16'hf000) return snd_pkg::REGION_RAM;
        if (a < 16'he000) return snd_pkg::REGION_DSP;
        return snd_pkg::REGION_NONE;
    endfunction

    function automatic logic [18:0] rom_addr_of(input logic [15:0] a, input logic [3:0] bank);
        if (a < 16'h8000)
            return {4'd0, a[14:0]};
        return snd_pkg::BANK_BASE + 19'(bank) * 19'h4000 + 19'(a - 16'h8000);
    endfunction

    // RAM index to addresses on either CPU
    function automatic logic [15:0] z80_addr_of(input logic [12:0] idx);
        return {idx[12] ? 4'hf : 4'hc, idx[11:0]};
    endfunction

    function automatic logic [22:0] main_addr_of(input logic [12:0] idx);
        logic [23:0] byte_addr;
        byte_addr = (idx[12] ? 24'hf1e000 : 24'hf18000) + {11'd0, idx[11:0], 1'b0};
        return byte_addr[23:1];
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else
            abort_run($sformatf("ERR %s: expected %0h, actual %0h", name, exp, act));
    endtask

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic z80_read(input logic [15:0] addr, output logic [7:0] din,
                            output logic cs, output logic [18:0] ra);
        z80_addr = addr;
        mreq_n   = 1'b0;
        rd_n     = 1'b0;
        tick();
        din    = z80_din;
        cs     = rom_cs;
        ra     = rom_addr;
        mreq_n = 1'b1;
        rd_n   = 1'b1;
        tick();
    endtask

    task automatic z80_write(input logic [15:0] addr, input logic [7:0] data);
        z80_addr = addr;
        z80_dout = data;
        mreq_n   = 1'b0;
        wr_n     = 1'b0;
        repeat (2) tick();  // strobe, then register update
        mreq_n = 1'b1;
        wr_n   = 1'b1;
        repeat (2) tick();
    endtask

    task automatic opcode_fetch(input logic [15:0] addr);
        z80_addr = addr;
        m1_n     = 1'b0;
        mreq_n   = 1'b0;
        rd_n     = 1'b0;
        #1;
        check_eq("fetch wait", (addr >= 16'h4000) ? 32'd0 : 32'd1, 32'(cpu_cen));
        tick();
        check_eq("fetch resume", 32'd1, 32'(cpu_cen));
        m1_n   = 1'b1;
        mreq_n = 1'b1;
        rd_n   = 1'b1;
        tick();
    endtask

    task automatic main_lock(input logic [22:0] a);
        int n;
        main_addr   = a;
        main_buse_n = 1'b0;
        main_ldswn  = 1'b1;
        #1;
        check_eq("bus request", 32'd0, 32'(z80_busrq_n));
        z80_busak_n = 1'b0;  // Z80 grants at once
        n = 0;
        while (main_busakn && n < 8) begin
            tick();
            n++;
        end
        check_eq("grant ticks", 32'd2, n);
    endtask

    task automatic main_release();
        main_buse_n = 1'b1;
        z80_busak_n = 1'b1;
        tick();
        check_eq("grant release", 32'd1, 32'(main_busakn));
    endtask

    task automatic shift_word(input logic [15:0] w);
        for (int b = 15; b >= 0; b--) begin
            dsp_sdo = w[b];
            dsp_ock = 1'b1;
            tick();
            dsp_ock = 1'b0;
            tick();
            if (dsp_psel)
                m_shift_r = {m_shift_r[14:0], w[b]};
            else
                m_shift_l = {m_shift_l[14:0], w[b]};
        end
    endtask

    task automatic rom_map_and_bank();
        logic [31:0] r;
        logic [7:0]  din;
        logic        cs;
        logic [18:0] ra;
        logic        rom_exp;
        snd_pkg::snd_region_e reg_exp;
        for (int i = 0; i < ROM_ITERS; i++) begin
            r = next_rand();
            z80_write(16'hd003, r[7:0]);
            m_bank    = r[3:0];
            m_dsp_rst = ~r[7];
            check_eq("dsp_rst", 32'(m_dsp_rst), 32'(dsp_rst));
            z80_read(16'hd007, din, cs, ra);
            check_eq("status", 32'({~m_irq, 3'b111, m_bank}), 32'(din));
            opcode_fetch(r[31:16]);
            for (int j = 0; j < 6; j++) begin
                r        = next_rand();
                rom_data = r[23:16];
                reg_exp  = region_of(r[15:0]);
                rom_exp  = (reg_exp == snd_pkg::REGION_ROM_LO) ||
                           (reg_exp == snd_pkg::REGION_ROM_BANK);
                z80_read(r[15:0], din, cs, ra);
                check_eq("rom_cs", 32'(rom_exp), 32'(cs));
                if (rom_exp) begin
                    check_eq("rom_addr", 32'(rom_addr_of(r[15:0], m_bank)), 32'(ra));
                    check_eq("rom read", 32'(r[23:16]), 32'(din));
                end
            end
        end
    endtask

    task automatic command_latch();
        logic [31:0] r;
        logic [7:0]  din;
        logic        cs;
        logic [18:0] ra;
        for (int i = 0; i < CMD_ITERS; i++) begin
            r = next_rand();
            z80_write(16'hd000, r[7:0]);
            z80_write(16'hd001, r[15:8]);
            z80_write(16'hd002, r[23:16]);
            m_cmd = r[23:0];
            m_irq = 1'b1;
            check_eq("irq set", 32'(m_irq), 32'(dsp_irq));
            z80_read(16'hd007, din, cs, ra);
            check_eq("status busy", 32'({~m_irq, 3'b111, m_bank}), 32'(din));
            dsp_pods_n = 1'b0;
            #1;
            check_eq("pbus high byte", 32'({8'd0, m_cmd[23:16]}), 32'(dsp_pbus_in));
            dsp_pids_n = 1'b0;
            tick();
            dsp_pids_n = 1'b1;
            tick();  // clear one cycle after the rise
            m_irq = 1'b0;
            check_eq("irq clear", 32'(m_irq), 32'(dsp_irq));
            check_eq("pbus low word", 32'(m_cmd[15:0]), 32'(dsp_pbus_in));
            dsp_pods_n = 1'b1;
            #1;
            check_eq("pbus idle", 32'hffff, 32'(dsp_pbus_in));
            tick();
        end
    endtask

    task automatic serial_audio();
        logic [31:0] r;
        int base;
        for (int f = 0; f < AUDIO_FRAMES; f++) begin
            r = next_rand();
            dsp_psel = 1'b1;
            shift_word(r[31:16]);  // right channel
            dsp_psel = 1'b0;
            shift_word(r[15:0]);
            base     = pulses;
            dsp_psel = 1'b1;
            tick();
            check_eq("sample", 32'd1, 32'(sample));
            check_eq("left", {16'd0, m_shift_l}, {16'd0, left});
            check_eq("right", {16'd0, m_shift_r}, {16'd0, right});
            tick();
            check_eq("sample end", 32'd0, 32'(sample));
            check_eq("sample count", base + 1, pulses);
        end
    endtask

    task automatic sample_rom_addr();
        logic [31:0] r;
        logic [15:0] ab_old;
        for (int i = 0; i < QADDR_ITERS; i++) begin
            r            = next_rand();
            dsp_pbus_out = r[15:0];
            dsp_ab       = r[31:16];
            ab_old       = r[31:16];
            dsp_pods_n   = 1'b0;
            tick();
            dsp_pods_n = 1'b1;
            tick();
            check_eq("qsnd_addr", 32'({ab_old[6:0], r[15:0]}), 32'(qsnd_addr));
            r      = next_rand();
            dsp_ab = r[15:0];
            #1;
            check_eq("qsnd hold", 32'(ab_old[6:0]), 32'(qsnd_addr[22:16]));
            tick();
            check_eq("qsnd upper", 32'(r[6:0]), 32'(qsnd_addr[22:16]));
        end
    endtask

    task automatic shared_ram_lock();
        logic [31:0] r;
        logic [12:0] idx;
        logic [7:0]  din;
        logic        cs;
        logic [18:0] ra;
        for (int i = 0; i < RAM_ITERS; i++) begin
            r   = next_rand();
            idx = r[12:0];
            main_lock(main_addr_of(idx));
            main_dout  = r[31:24];
            main_ldswn = 1'b0;
            tick();
            main_ldswn  = 1'b1;
            m_ram[idx] = r[31:24];
            main_release();
            z80_read(z80_addr_of(idx), din, cs, ra);
            check_eq("z80 sees main write", 32'(m_ram[idx]), 32'(din));
            r   = next_rand();
            idx = r[12:0];
            z80_write(z80_addr_of(idx), r[23:16]);
            m_ram[idx] = r[23:16];
            main_lock(main_addr_of(idx));
            tick();
            check_eq("main sees z80 write", 32'(m_ram[idx]), 32'(main_din));
            main_release();
        end
    endtask

    task automatic irq_timer();
        int n;
        n = 0;
        while (int_n && n < 2 * snd_pkg::INT_PERIOD) begin
            tick();
            n++;
        end
        check_eq("int first fall", snd_pkg::INT_PERIOD, edges);
        repeat (40) begin
            tick();
            check_eq("int held", 32'd0, 32'(int_n));
        end
        m1_n   = 1'b0;  // acknowledge cycle
        iorq_n = 1'b0;
        tick();
        check_eq("int ack", 32'd1, 32'(int_n));
        m1_n   = 1'b1;
        iorq_n = 1'b1;
        n = 0;
        while (int_n && n < 2 * snd_pkg::INT_PERIOD) begin
            tick();
            n++;
        end
        check_eq("int second fall", 2 * snd_pkg::INT_PERIOD, edges);
    endtask

    initial begin
        seed = 32'hd9563f24;
        rst = 1'b1;
        cen8 = 1'b1;
        z80_addr = '0;
        z80_dout = '0;
        rom_data = '0;
        {mreq_n, rd_n, wr_n, m1_n, iorq_n, z80_busak_n} = 6'b111111;
        dsp_ab = '0;
        dsp_pbus_out = '0;
        {dsp_pods_n, dsp_pids_n, dsp_iack} = 3'b110;
        {dsp_sdo, dsp_ock, dsp_psel} = 3'b001;
        main_addr = '0;
        main_dout = '0;
        main_ldswn = 1'b1;
        main_buse_n = 1'b1;
        m_bank = '0;
        m_dsp_rst = 1'b1;
        m_irq = 1'b0;
        m_cmd = '0;
        repeat (10) @(posedge clk);
        #2 rst = 1'b0;
        check_eq("reset rom_cs", 32'd0, 32'(rom_cs));
        check_eq("reset sample", 32'd0, 32'(sample));
        check_eq("reset irq", 32'd0, 32'(dsp_irq));
        check_eq("reset int_n", 32'd1, 32'(int_n));
        check_eq("reset busrq", 32'd1, 32'(z80_busrq_n));
        check_eq("reset busakn", 32'd1, 32'(main_busakn));
        check_eq("reset dsp_rst", 32'd1, 32'(dsp_rst));
        rom_map_and_bank();
        command_latch();
        serial_audio();
        sample_rom_addr();
        shared_ram_lock();
        irq_timer();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: qsound_glue.f
design/snd_pkg.sv
design/sound_bus_ctrl.sv
design/int_timer.sv
design/bus_lock.sv
design/shared_ram.sv
design/dsp_port.sv
design/serial_audio_rx.sv
design/qsound_glue.sv
verification/tb_qsound_glue.sv

// File: run.sh
#!/bin/sh
# build the qsound_glue testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_qsound_glue -f qsound_glue.f

out=$(./obj_dir/Vtb_qsound_glue 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
